/* verilog.f */
+incdir+verilog
+incdir+dv
verilog/cu_isa_pkg.sv
verilog/cu_ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/control_sequencer.sv
verilog/control_unit.sv
dv/control_unit_tb.sv

/* Bender.yml */
package:
  name: control_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cu_isa_pkg.sv
      - verilog/cu_ctrl_pkg.sv
      - verilog/instr_decoder.sv
      - verilog/control_sequencer.sv
      - verilog/control_unit.sv
  - target: simulation
    include_dirs:
      - verilog
      - dv
    files:
      - dv/control_unit_tb.sv

/* dv/cu_tb_vectors.svh */
`ifndef CU_TB_VECTORS_SVH
`define CU_TB_VECTORS_SVH

// expected words shared by several rows
localparam fetch_ctrl_t FETCH_IN  = '{1'b1, 1'b1, 1'b0, 1'b0};
localparam fetch_ctrl_t FETCH_LDM = '{1'b1, 1'b0, 1'b1, 1'b0};
localparam fetch_ctrl_t FETCH_IRQ = '{1'b0, 1'b0, 1'b1, 1'b0};
localparam mem_ctrl_t MEM_PUSH_REG = '{1'b0, 1'b1, 1'b1, 1'b0, ADDR_STACK, SRC_REGISTER};
localparam mem_ctrl_t MEM_POP_REG  = '{1'b1, 1'b0, 1'b0, 1'b1, ADDR_STACK, SRC_REGISTER};
localparam mem_ctrl_t MEM_LDD      = '{1'b1, 1'b0, 1'b0, 1'b0, ADDR_REGISTER, SRC_FLAGS};
localparam mem_ctrl_t MEM_CALL     = '{1'b0, 1'b0, 1'b1, 1'b0, ADDR_NONE, SRC_PC_HIGH};
localparam mem_ctrl_t MEM_POP      = '{1'b0, 1'b0, 1'b0, 1'b1, ADDR_NONE, SRC_FLAGS};
localparam wb_ctrl_t WB_ALU_WR = '{1'b1, WB_ALU, 1'b0};
localparam wb_ctrl_t WB_MEM_WR = '{1'b1, WB_MEMORY, 1'b0};
localparam wb_ctrl_t WB_IMM_WR = '{1'b1, WB_IMMEDIATE, 1'b0};
localparam wb_ctrl_t WB_OUT    = '{1'b0, WB_ALU, 1'b1};
localparam ex_ctrl_t EX_RETI = '{ALU_PASS, JUMP_NONE, CARRY_FROM_ALU, 1'b1, 1'b1};

function automatic ex_ctrl_t alu_ex(input alu_op_t op);
	return '{op, JUMP_NONE, CARRY_FROM_ALU, 1'b0, 1'b1};
endfunction

function automatic ex_ctrl_t carry_ex(input carry_sel_t sel);
	return '{ALU_PASS, JUMP_NONE, sel, 1'b0, 1'b1};
endfunction

function automatic ex_ctrl_t jump_ex(input jump_sel_t sel);
	return '{ALU_PASS, sel, CARRY_FROM_ALU, 1'b0, 1'b0};
endfunction

// columns: instruction, interrupt, sequence kind, then cycle 0 fetch, ex, mem, wb
// register fields 9:0 stay zero here and are filled randomly when applied
task automatic load_vectors();
	add_row(16'h0000, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_NOT), MEM_NOP, WB_ALU_WR);
	add_row(16'h0800, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_INC), MEM_NOP, WB_ALU_WR);
	add_row(16'h0c00, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_DEC), MEM_NOP, WB_ALU_WR);
	add_row(16'h1000, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_ADD), MEM_NOP, WB_ALU_WR);
	add_row(16'h1800, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_SUB), MEM_NOP, WB_ALU_WR);
	add_row(16'h2000, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_AND), MEM_NOP, WB_ALU_WR);
	add_row(16'h2800, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_OR), MEM_NOP, WB_ALU_WR);
	add_row(16'h3000, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_SHL), MEM_NOP, WB_ALU_WR);
	add_row(16'h3800, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_SHR), MEM_NOP, WB_ALU_WR);
	add_row(16'h4000, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'h4800, 1'b0, KIND_NONE, FETCH_NOP, carry_ex(CARRY_SET), MEM_NOP, WB_NOP);
	add_row(16'h5000, 1'b0, KIND_NONE, FETCH_NOP, carry_ex(CARRY_CLEAR), MEM_NOP, WB_NOP);
	add_row(16'h5800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_OUT);
	add_row(16'h6000, 1'b0, KIND_NONE, FETCH_IN, EX_NOP, MEM_NOP, WB_ALU_WR);
	add_row(16'h6800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_PUSH_REG, WB_NOP);
	add_row(16'h7000, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_POP_REG, WB_MEM_WR);
	add_row(16'h7800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'h8000, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_ALU_WR);
	add_row(16'h8800, 1'b0, KIND_NONE, FETCH_LDM, EX_NOP, MEM_NOP, WB_IMM_WR);
	add_row(16'h9000, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_LDD, WB_MEM_WR);
	// STD slot and the old shift codes
	add_row(16'h9800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'ha000, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'hb800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'hc000, 1'b0, KIND_NONE, FETCH_NOP, jump_ex(JUMP_ZERO), MEM_NOP, WB_NOP);
	add_row(16'hc800, 1'b0, KIND_NONE, FETCH_NOP, jump_ex(JUMP_NEG), MEM_NOP, WB_NOP);
	add_row(16'hd000, 1'b0, KIND_NONE, FETCH_NOP, jump_ex(JUMP_CARRY), MEM_NOP, WB_NOP);
	add_row(16'hd800, 1'b0, KIND_NONE, FETCH_NOP, jump_ex(JUMP_ALWAYS), MEM_NOP, WB_NOP);
	add_row(16'he000, 1'b0, KIND_CALL, FETCH_NOP, jump_ex(JUMP_ALWAYS), MEM_CALL, WB_NOP);
	add_row(16'he800, 1'b0, KIND_RET, FETCH_NOP, EX_NOP, MEM_POP, WB_NOP);
	add_row(16'hf000, 1'b0, KIND_RETI, FETCH_NOP, EX_RETI, MEM_POP, WB_NOP);
	add_row(16'hf800, 1'b0, KIND_NONE, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
	// interrupt beats both a plain ALU op and a call
	add_row(16'h1000, 1'b1, KIND_IRQ, FETCH_IRQ, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'he000, 1'b1, KIND_IRQ, FETCH_IRQ, EX_NOP, MEM_NOP, WB_NOP);
	add_row(16'h1800, 1'b0, KIND_NONE, FETCH_NOP, alu_ex(ALU_SUB), MEM_NOP, WB_ALU_WR);
endtask

`endif

/* dv/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defines.svh"

module control_unit_tb
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
();

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_CALL,
		KIND_RET,
		KIND_RETI,
		KIND_IRQ
	} seq_kind_t;

	typedef struct packed {
		instr_t      instr;
		logic        irq;
		seq_kind_t   kind;
		fetch_ctrl_t fetch;
		ex_ctrl_t    ex;
		mem_ctrl_t   mem;
		wb_ctrl_t    wb;
	} entry_t;

	// one-operand NOP with empty register fields
	localparam instr_t NOP_INSTR = 16'h4000;
	localparam int WAIT_LIMIT = 20;

	logic        clk;
	logic        reset;
	logic        interrupt;
	instr_t      instruction;
	fetch_ctrl_t fetch_ctrl;
	ex_ctrl_t    ex_ctrl;
	mem_ctrl_t   mem_ctrl;
	wb_ctrl_t    wb_ctrl;
	entry_t      vectors[$];
	integer      seed;

	control_unit dut0 (
		.clk         (clk),
		.reset       (reset),
		.interrupt   (interrupt),
		.instruction (instruction),
		.fetch_ctrl  (fetch_ctrl),
		.ex_ctrl     (ex_ctrl),
		.mem_ctrl    (mem_ctrl),
		.wb_ctrl     (wb_ctrl)
	);

	always #4 clk = ~clk;

	task automatic add_row(input instr_t instr, input logic irq, input seq_kind_t kind,
		input fetch_ctrl_t f, input ex_ctrl_t e, input mem_ctrl_t m, input wb_ctrl_t w);
		entry_t row;
		row = '{instr, irq, kind, f, e, m, w};
		vectors.push_back(row);
	endtask

	`include "cu_tb_vectors.svh"

	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_fetch(input string name, input fetch_ctrl_t expected);
		if (fetch_ctrl !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %p actual %p", $time, name, expected, fetch_ctrl);
			stop_run();
		end
	endtask

	task automatic check_ex(input string name, input ex_ctrl_t expected);
		if (ex_ctrl !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %p actual %p", $time, name, expected, ex_ctrl);
			stop_run();
		end
	endtask

	task automatic check_mem(input string name, input mem_ctrl_t expected);
		if (mem_ctrl !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %p actual %p", $time, name, expected, mem_ctrl);
			stop_run();
		end
	endtask

	task automatic check_wb(input string name, input wb_ctrl_t expected);
		if (wb_ctrl !== expected)
		begin
			$display("[FAIL] t=%0t %s expected %p actual %p", $time, name, expected, wb_ctrl);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected)
		begin
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_words(input string tag, input fetch_ctrl_t f, input ex_ctrl_t e,
		input mem_ctrl_t m, input wb_ctrl_t w);
		check_fetch({tag, " fetch_ctrl"}, f);
		check_ex({tag, " ex_ctrl"}, e);
		check_mem({tag, " mem_ctrl"}, m);
		check_wb({tag, " wb_ctrl"}, w);
	endtask

	function automatic instr_t random_fields();
		return instr_t'($random(seed) & 32'h3ff);
	endfunction

	// cycles after cycle 0 until the pc runs again
	function automatic int seq_length(input seq_kind_t kind);
		case (kind)
			KIND_CALL: return 1;
			KIND_RET:  return 3;
			KIND_RETI: return 4;
			KIND_IRQ:  return `CU_DRAIN_CYCLES + 3;
			default:   return 0;
		endcase
	endfunction

	// expected words for a later cycle of a sequence, pc held
	task automatic step_words(input seq_kind_t kind, input int step, output fetch_ctrl_t f,
		output ex_ctrl_t e, output mem_ctrl_t m, output wb_ctrl_t w);
		int offset;
		f = FETCH_NOP;
		f.pc_enable = 1'b0;
		e = EX_NOP;
		m = MEM_NOP;
		w = WB_NOP;
		case (kind)
			KIND_CALL:
			begin
				m.push = 1'b1;
				m.src_sel = SRC_PC_LOW;
			end
			KIND_RET, KIND_RETI:
			begin
				// reti has one more pop ahead of the ret tail
				offset = (kind == KIND_RETI) ? 1 : 0;
				if (step <= 1 + offset)
					m.pop = 1'b1;
				else if (step == 3 + offset)
					f.pc_from_mem = 1'b1;
			end
			KIND_IRQ:
			begin
				if (step <= `CU_DRAIN_CYCLES)
					f.flush = 1'b1;
				else
				begin
					m.push = 1'b1;
					case (step - `CU_DRAIN_CYCLES)
						1: m.src_sel = SRC_PC_HIGH;
						2: m.src_sel = SRC_PC_LOW;
						default: m.src_sel = SRC_FLAGS;
					endcase
				end
			end
			default:
				f.pc_enable = 1'b1;
		endcase
	endtask

	initial
	begin
		fetch_ctrl_t f;
		ex_ctrl_t    e;
		mem_ctrl_t   m;
		wb_ctrl_t    w;
		int          step;
		int          expect_len;
		string       tag;

		seed = 32'h167e;
		clk = 1'b0;
		reset = 1'b0;
		interrupt = 1'b0;
		instruction = NOP_INSTR;
		load_vectors();

		repeat (16) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		check_words("after reset", FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);

		foreach (vectors[i])
		begin
			@(posedge clk);
			instruction <= vectors[i].instr | random_fields();
			interrupt   <= vectors[i].irq;
			@(negedge clk);
			tag = $sformatf("entry %0d", i);
			check_words(tag, vectors[i].fetch, vectors[i].ex, vectors[i].mem, vectors[i].wb);

			// later cycles, then back to plain decode of a NOP
			expect_len = seq_length(vectors[i].kind);
			for (step = 1; step <= WAIT_LIMIT; step++)
			begin
				@(posedge clk);
				instruction <= NOP_INSTR | random_fields();
				interrupt   <= 1'b0;
				@(negedge clk);
				if (fetch_ctrl.pc_enable)
					break;
				if (step > expect_len)
					check_count({tag, " sequence length"}, expect_len, step);
				step_words(vectors[i].kind, step, f, e, m, w);
				check_words($sformatf("%s step %0d", tag, step), f, e, m, w);
			end
			if (step > WAIT_LIMIT)
			begin
				$display("timed out after %0d cycles waiting for pc_enable in %s",
					WAIT_LIMIT, tag);
				stop_run();
			end
			check_count({tag, " sequence length"}, expect_len, step - 1);
			check_words({tag, " return"}, FETCH_NOP, EX_NOP, MEM_NOP, WB_NOP);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         interrupt,
	input  instr_t      instruction,
	output fetch_ctrl_t fetch_ctrl,
	output ex_ctrl_t    ex_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output wb_ctrl_t    wb_ctrl
);

	// decoded words before the sequencer overrides them
	fetch_ctrl_t dec_fetch;
	ex_ctrl_t    dec_ex;
	mem_ctrl_t   dec_mem;
	wb_ctrl_t    dec_wb;
	seq_req_t    seq_req;

	instr_decoder u_decoder (
		.instruction (instruction),
		.dec_fetch   (dec_fetch),
		.dec_ex      (dec_ex),
		.dec_mem     (dec_mem),
		.dec_wb      (dec_wb),
		.seq_req     (seq_req)
	);

	control_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.interrupt  (interrupt),
		.seq_req    (seq_req),
		.dec_fetch  (dec_fetch),
		.dec_ex     (dec_ex),
		.dec_mem    (dec_mem),
		.dec_wb     (dec_wb),
		.fetch_ctrl (fetch_ctrl),
		.ex_ctrl    (ex_ctrl),
		.mem_ctrl   (mem_ctrl),
		.wb_ctrl    (wb_ctrl)
	);

endmodule

`default_nettype wire

/* verilog/control_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defines.svh"

module control_sequencer
	import cu_ctrl_pkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         interrupt,
	input  seq_req_t    seq_req,
	input  fetch_ctrl_t dec_fetch,
	input  ex_ctrl_t    dec_ex,
	input  mem_ctrl_t   dec_mem,
	input  wb_ctrl_t    dec_wb,
	output fetch_ctrl_t fetch_ctrl,
	output ex_ctrl_t    ex_ctrl,
	output mem_ctrl_t   mem_ctrl,
	output wb_ctrl_t    wb_ctrl
);

	localparam int DRAIN_W = $clog2(`CU_DRAIN_CYCLES + 1);

	typedef logic [DRAIN_W-1:0] drain_cnt_t;

	localparam drain_cnt_t DRAIN_LAST = drain_cnt_t'(`CU_DRAIN_CYCLES - 1);

	seq_state_t state;
	seq_state_t next_state;
	drain_cnt_t drain_cnt;

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE:
			begin
				// interrupt wins over whatever is being decoded
				if (interrupt)
					next_state = ST_DRAIN;
				else if (seq_req == SEQ_CALL)
					next_state = ST_CALL_PUSH_LOW;
				else if (seq_req == SEQ_RET)
					next_state = ST_POP_PC_LOW;
				else if (seq_req == SEQ_RETI)
					next_state = ST_POP_PC_HIGH;
			end
			ST_CALL_PUSH_LOW:
				next_state = ST_IDLE;
			ST_DRAIN:
				if (drain_cnt == DRAIN_LAST)
					next_state = ST_PUSH_PC_HIGH;
			ST_PUSH_PC_HIGH:
				next_state = ST_PUSH_PC_LOW;
			ST_PUSH_PC_LOW:
				next_state = ST_PUSH_FLAGS;
			ST_PUSH_FLAGS:
				next_state = ST_IDLE;
			ST_POP_PC_HIGH:
				next_state = ST_POP_PC_LOW;
			ST_POP_PC_LOW:
				next_state = ST_PC_LOAD_WAIT;
			ST_PC_LOAD_WAIT:
				next_state = ST_PC_LOAD;
			default:
				next_state = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state     <= ST_IDLE;
			drain_cnt <= '0;
		end
		else
		begin
			state <= next_state;
			if (state == ST_DRAIN)
				drain_cnt <= drain_cnt + 1'b1;
			else
				drain_cnt <= '0;
		end
	end

	always_comb
	begin
		fetch_ctrl = FETCH_NOP;
		ex_ctrl    = EX_NOP;
		mem_ctrl   = MEM_NOP;
		wb_ctrl    = WB_NOP;

		if (state == ST_IDLE)
		begin
			if (interrupt)
			begin
				// hold the pc and start squashing in-flight work
				fetch_ctrl.pc_enable = 1'b0;
				fetch_ctrl.flush     = 1'b1;
			end
			else
			begin
				fetch_ctrl = dec_fetch;
				ex_ctrl    = dec_ex;
				mem_ctrl   = dec_mem;
				wb_ctrl    = dec_wb;
				case (seq_req)
					SEQ_CALL:
					begin
						mem_ctrl.push    = 1'b1;
						mem_ctrl.src_sel = SRC_PC_HIGH;
						ex_ctrl.jump_sel = JUMP_ALWAYS;
					end
					SEQ_RET:
						mem_ctrl.pop = 1'b1;
					SEQ_RETI:
					begin
						mem_ctrl.pop          = 1'b1;
						ex_ctrl.flag_from_mem = 1'b1;
						ex_ctrl.flag_enable   = 1'b1;
					end
				endcase
			end
		end
		else
		begin
			// instruction input ignored, pc frozen
			fetch_ctrl.pc_enable = 1'b0;
			case (state)
				ST_CALL_PUSH_LOW, ST_PUSH_PC_LOW:
				begin
					mem_ctrl.push    = 1'b1;
					mem_ctrl.src_sel = SRC_PC_LOW;
				end
				ST_DRAIN:
					fetch_ctrl.flush = 1'b1;
				ST_PUSH_PC_HIGH:
				begin
					mem_ctrl.push    = 1'b1;
					mem_ctrl.src_sel = SRC_PC_HIGH;
				end
				ST_PUSH_FLAGS:
				begin
					mem_ctrl.push    = 1'b1;
					mem_ctrl.src_sel = SRC_FLAGS;
				end
				ST_POP_PC_HIGH, ST_POP_PC_LOW:
					mem_ctrl.pop = 1'b1;
				// popped pc reaches the memory stage output here
				ST_PC_LOAD:
					fetch_ctrl.pc_from_mem = 1'b1;
				default:
					fetch_ctrl.pc_from_mem = 1'b0;
			endcase
		end
	end

	// decoded stack ops and sequencer stack ops must not collide
	a_no_push_pop: assert property (@(posedge clk) disable iff (!reset)
		!(mem_ctrl.push && mem_ctrl.pop));

	a_pc_load_only: assert property (@(posedge clk) disable iff (!reset)
		fetch_ctrl.pc_from_mem |-> (state == ST_PC_LOAD));

endmodule

`default_nettype wire

/* verilog/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defines.svh"

module instr_decoder
	import cu_isa_pkg::*;
	import cu_ctrl_pkg::*;
(
	input  instr_t      instruction,
	output fetch_ctrl_t dec_fetch,
	output ex_ctrl_t    dec_ex,
	output mem_ctrl_t   dec_mem,
	output wb_ctrl_t    dec_wb,
	output seq_req_t    seq_req
);

	instr_group_t group;
	func_t        func;

	assign group = instr_group_t'(instruction[`CU_GROUP_MSB:`CU_GROUP_LSB]);
	assign func  = instruction[`CU_FUNC_MSB:`CU_FUNC_LSB];

	always_comb
	begin
		// start from a bubble, each class overrides what it needs
		dec_fetch = FETCH_NOP;
		dec_ex    = EX_NOP;
		dec_mem   = MEM_NOP;
		dec_wb    = WB_NOP;
		seq_req   = SEQ_NONE;

		case (group)
			GROUP_RTYPE:
			begin
				dec_ex.flag_enable = 1'b1;
				dec_wb.reg_write   = 1'b1;
				dec_wb.wb_sel      = WB_ALU;
				case (func)
					FN_NOT:
						dec_ex.alu_op = ALU_NOT;
					FN_INCDEC:
						dec_ex.alu_op = instruction[`CU_VARIANT_BIT] ? ALU_DEC : ALU_INC;
					FN_ADD:
						dec_ex.alu_op = ALU_ADD;
					FN_SUB:
						dec_ex.alu_op = ALU_SUB;
					FN_AND:
						dec_ex.alu_op = ALU_AND;
					FN_OR:
						dec_ex.alu_op = ALU_OR;
					FN_SHL:
						dec_ex.alu_op = ALU_SHL;
					FN_SHR:
						dec_ex.alu_op = ALU_SHR;
					default:
						dec_ex.alu_op = ALU_PASS;
				endcase
			end

			GROUP_ONE_OP:
			begin
				case (func)
					FN_SETC:
					begin
						dec_ex.carry_sel   = CARRY_SET;
						dec_ex.flag_enable = 1'b1;
					end
					FN_CLRC:
					begin
						dec_ex.carry_sel   = CARRY_CLEAR;
						dec_ex.flag_enable = 1'b1;
					end
					FN_OUT:
						dec_wb.out_enable = 1'b1;
					FN_IN:
					begin
						dec_fetch.inport_sel = 1'b1;
						dec_wb.reg_write     = 1'b1;
					end
					FN_PUSH:
					begin
						dec_mem.write    = 1'b1;
						dec_mem.push     = 1'b1;
						dec_mem.addr_sel = ADDR_STACK;
						dec_mem.src_sel  = SRC_REGISTER;
					end
					FN_POP:
					begin
						dec_mem.read     = 1'b1;
						dec_mem.pop      = 1'b1;
						dec_mem.addr_sel = ADDR_STACK;
						dec_mem.src_sel  = SRC_REGISTER;
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_MEMORY;
					end
					// NOP and the spare code stay a bubble
					default:
						dec_ex.alu_op = ALU_PASS;
				endcase
			end

			GROUP_TWO_OP:
			begin
				case (func)
					FN_MOV:
					begin
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_ALU;
					end
					// immediate sits in the next word, so squash it in fetch
					FN_LDM:
					begin
						dec_fetch.flush  = 1'b1;
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_IMMEDIATE;
					end
					FN_LDD:
					begin
						dec_mem.read     = 1'b1;
						dec_mem.addr_sel = ADDR_REGISTER;
						dec_wb.reg_write = 1'b1;
						dec_wb.wb_sel    = WB_MEMORY;
					end
					// STD and the old shift codes fall through as NOP
					default:
						dec_wb.reg_write = 1'b0;
				endcase
			end

			GROUP_BRANCH:
			begin
				case (func)
					FN_JZ:
						dec_ex.jump_sel = JUMP_ZERO;
					FN_JN:
						dec_ex.jump_sel = JUMP_NEG;
					FN_JC:
						dec_ex.jump_sel = JUMP_CARRY;
					FN_JMP:
						dec_ex.jump_sel = JUMP_ALWAYS;
					// stack and pc handling belong to the sequencer
					FN_CALL:
						seq_req = SEQ_CALL;
					FN_RET:
						seq_req = SEQ_RET;
					FN_RETI:
						seq_req = SEQ_RETI;
					default:
						seq_req = SEQ_NONE;
				endcase
			end

			default:
				seq_req = SEQ_NONE;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/cu_ctrl_pkg.sv */
`default_nettype none

package cu_ctrl_pkg;

	import cu_isa_pkg::*;

	// msb marks a taken-capable jump, low bits pick the flag
	typedef enum logic [2:0] {
		JUMP_NONE   = 3'b000,
		JUMP_ZERO   = 3'b100,
		JUMP_NEG    = 3'b101,
		JUMP_CARRY  = 3'b110,
		JUMP_ALWAYS = 3'b111
	} jump_sel_t;

	typedef enum logic [1:0] {
		CARRY_FROM_ALU = 2'b00,
		CARRY_SET      = 2'b01,
		CARRY_CLEAR    = 2'b10
	} carry_sel_t;

	typedef enum logic [1:0] {
		ADDR_NONE     = 2'b00,
		ADDR_REGISTER = 2'b01,
		ADDR_STACK    = 2'b10
	} mem_addr_sel_t;

	typedef enum logic [1:0] {
		SRC_FLAGS    = 2'b00,
		SRC_PC_HIGH  = 2'b01,
		SRC_PC_LOW   = 2'b10,
		SRC_REGISTER = 2'b11
	} mem_src_sel_t;

	typedef enum logic [1:0] {
		WB_IMMEDIATE = 2'b00,
		WB_MEMORY    = 2'b01,
		WB_ALU       = 2'b10
	} wb_sel_t;

	// multi-cycle operations requested by the decoder
	typedef enum logic [1:0] {
		SEQ_NONE = 2'b00,
		SEQ_CALL = 2'b01,
		SEQ_RET  = 2'b10,
		SEQ_RETI = 2'b11
	} seq_req_t;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_CALL_PUSH_LOW,
		ST_DRAIN,
		ST_PUSH_PC_HIGH,
		ST_PUSH_PC_LOW,
		ST_PUSH_FLAGS,
		ST_POP_PC_HIGH,
		ST_POP_PC_LOW,
		ST_PC_LOAD_WAIT,
		ST_PC_LOAD
	} seq_state_t;

	typedef struct packed {
		logic pc_enable;
		logic inport_sel;
		logic flush;
		logic pc_from_mem;
	} fetch_ctrl_t;

	typedef struct packed {
		alu_op_t    alu_op;
		jump_sel_t  jump_sel;
		carry_sel_t carry_sel;
		logic       flag_from_mem;
		logic       flag_enable;
	} ex_ctrl_t;

	typedef struct packed {
		logic          read;
		logic          write;
		logic          push;
		logic          pop;
		mem_addr_sel_t addr_sel;
		mem_src_sel_t  src_sel;
	} mem_ctrl_t;

	typedef struct packed {
		logic    reg_write;
		wb_sel_t wb_sel;
		logic    out_enable;
	} wb_ctrl_t;

	// bubble words, fetch keeps running
	localparam fetch_ctrl_t FETCH_NOP = '{
		pc_enable: 1'b1, inport_sel: 1'b0, flush: 1'b0, pc_from_mem: 1'b0};
	localparam ex_ctrl_t EX_NOP = '{
		alu_op: ALU_PASS, jump_sel: JUMP_NONE, carry_sel: CARRY_FROM_ALU,
		flag_from_mem: 1'b0, flag_enable: 1'b0};
	localparam mem_ctrl_t MEM_NOP = '{
		read: 1'b0, write: 1'b0, push: 1'b0, pop: 1'b0,
		addr_sel: ADDR_NONE, src_sel: SRC_FLAGS};
	localparam wb_ctrl_t WB_NOP = '{
		reg_write: 1'b0, wb_sel: WB_ALU, out_enable: 1'b0};

endpackage

`default_nettype wire

/* verilog/cu_isa_pkg.sv */
`default_nettype none

`include "cu_defines.svh"

package cu_isa_pkg;

	typedef logic [`CU_INSTR_W-1:0] instr_t;
	typedef logic [`CU_FUNC_MSB-`CU_FUNC_LSB:0] func_t;

	typedef enum logic [1:0] {
		GROUP_RTYPE  = 2'b00,
		GROUP_ONE_OP = 2'b01,
		GROUP_TWO_OP = 2'b10,
		GROUP_BRANCH = 2'b11
	} instr_group_t;

	// codes as seen by the execute stage ALU
	typedef enum logic [3:0] {
		ALU_NOT  = 4'd0,
		ALU_INC  = 4'd1,
		ALU_DEC  = 4'd2,
		ALU_ADD  = 4'd3,
		ALU_SUB  = 4'd4,
		ALU_AND  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_SHL  = 4'd7,
		ALU_SHR  = 4'd8,
		ALU_PASS = 4'd15
	} alu_op_t;

	// r-type functions, INC and DEC share one code
	localparam func_t FN_NOT    = 3'd0;
	localparam func_t FN_INCDEC = 3'd1;
	localparam func_t FN_ADD    = 3'd2;
	localparam func_t FN_SUB    = 3'd3;
	localparam func_t FN_AND    = 3'd4;
	localparam func_t FN_OR     = 3'd5;
	localparam func_t FN_SHL    = 3'd6;
	localparam func_t FN_SHR    = 3'd7;

	// one-operand group
	localparam func_t FN_NOP  = 3'd0;
	localparam func_t FN_SETC = 3'd1;
	localparam func_t FN_CLRC = 3'd2;
	localparam func_t FN_OUT  = 3'd3;
	localparam func_t FN_IN   = 3'd4;
	localparam func_t FN_PUSH = 3'd5;
	localparam func_t FN_POP  = 3'd6;

	// two-operand group
	localparam func_t FN_MOV = 3'd0;
	localparam func_t FN_LDM = 3'd1;
	localparam func_t FN_LDD = 3'd2;

	// branch group
	localparam func_t FN_JZ   = 3'd0;
	localparam func_t FN_JN   = 3'd1;
	localparam func_t FN_JC   = 3'd2;
	localparam func_t FN_JMP  = 3'd3;
	localparam func_t FN_CALL = 3'd4;
	localparam func_t FN_RET  = 3'd5;
	localparam func_t FN_RETI = 3'd6;

endpackage

`default_nettype wire

/* verilog/cu_defines.svh */
`ifndef CU_DEFINES_SVH
`define CU_DEFINES_SVH

// instruction word
`define CU_INSTR_W 16

// group field, selects one of four opcode groups
`define CU_GROUP_MSB 15
`define CU_GROUP_LSB 14

// function field inside a group
`define CU_FUNC_MSB 13
`define CU_FUNC_LSB 11

// picks INC or DEC within the shared R-type function
`define CU_VARIANT_BIT 10

// pipeline depth to empty before an interrupt push
`define CU_DRAIN_CYCLES 5

`endif
